// File: logic/i2f_cfg_pkg.sv
// Converter configuration constants
package i2f_cfg_pkg;

  // Number of conversion lanes fed in round-robin order by the dispatcher
  // With a three-cycle lane, four lanes cover one request per cycle
  localparam int unsigned NUM_LANES = 4;

  // Width of the integer operand in bits
  localparam int unsigned INT_W = 32;

  // Busy cycles of one lane between its start and its done strobe
  // The lane FSM counts through these steps one at a time
  localparam int unsigned LANE_LAT = 3;

  // Width of the request tag that travels with each operand
  // The tag is not interpreted inside the converter, only carried along
  localparam int unsigned TAG_W = 4;

  // Width of a lane index, used by the round-robin pointer and the
  // one-hot to binary decode in the collector
  localparam int unsigned LANE_IDX_W = 2;

endpackage : i2f_cfg_pkg

// File: logic/i2f_fmt_pkg.sv
// Single-precision format definitions
package i2f_fmt_pkg;

  // Exponent field width of an IEEE-754 single-precision word
  localparam int unsigned EXP_W = 8;

  // Stored mantissa width, without the hidden leading one
  localparam int unsigned MAN_W = 23;

  // Exponent bias, so an exponent field of 127 encodes 2^0
  localparam int unsigned EXP_BIAS = 127;

  // Total width of the packed result word
  localparam int unsigned F32_W = 1 + EXP_W + MAN_W;

  // One result word seen two ways
  // The lane builds the word through the fields view
  // The collector and the top level pass it on as a plain bus word
  typedef union packed {
    // Whole word as it appears on the output bus
    logic [F32_W-1:0] raw;
    // Sign, biased exponent and stored mantissa, MSB first
    struct packed {
      logic             sign;
      logic [EXP_W-1:0] exp;
      logic [MAN_W-1:0] man;
    } fields;
  } f32_word_u;

endpackage : i2f_fmt_pkg

// File: logic/lzc.sv
// Leading and trailing zero counter
`timescale 1ns/1ps

module lzc #(
  // Width of the input vector, at least 2
  parameter int unsigned WIDTH     = 2,
  // 0 counts trailing zeros from the LSB, 1 counts leading zeros from the MSB
  parameter bit          MODE      = 1'b0,
  // Derived width of the count, leave at its default
  parameter int unsigned CNT_WIDTH = unsigned'($clog2(WIDTH))
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  // Input in counting order, so bit 0 is always the first bit looked at
  logic [WIDTH-1:0] in_tmp;

  // Bit position of every input bit, used as the leaf indices of the tree
  logic [WIDTH-1:0][CNT_WIDTH-1:0] index_lut;

  // Tree nodes in heap order, node 0 is the root
  // A node's select bit says that some bit below it is set
  logic [2**CNT_WIDTH-2:0]                sel_nodes;
  logic [2**CNT_WIDTH-2:0][CNT_WIDTH-1:0] index_nodes;

  // In leading-zero mode the MSB becomes position 0
  always_comb begin
    for (int unsigned i = 0; i < WIDTH; i++) begin
      in_tmp[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
    end
  end

  for (genvar j = 0; j < WIDTH; j++) begin : gen_lut
    assign index_lut[j] = (CNT_WIDTH)'(unsigned'(j));
  end

  for (genvar lvl = 0; lvl < CNT_WIDTH; lvl++) begin : gen_levels
    if (lvl == CNT_WIDTH - 1) begin : gen_leaves
      // Bottom level looks at pairs of input bits
      for (genvar k = 0; k < 2**lvl; k++) begin : gen_node
        if (2 * k < WIDTH - 1) begin : gen_pair
          assign sel_nodes[2**lvl-1+k] = in_tmp[2*k] | in_tmp[2*k+1];
          // The lower position wins when both bits are set
          assign index_nodes[2**lvl-1+k] = in_tmp[2*k] ? index_lut[2*k]
                                                        : index_lut[2*k+1];
        end else if (2 * k == WIDTH - 1) begin : gen_single
          // Odd width leaves one bit without a partner
          assign sel_nodes[2**lvl-1+k]   = in_tmp[2*k];
          assign index_nodes[2**lvl-1+k] = index_lut[2*k];
        end else begin : gen_pad
          // Padding nodes past the end of the input
          assign sel_nodes[2**lvl-1+k]   = 1'b0;
          assign index_nodes[2**lvl-1+k] = '0;
        end
      end
    end else begin : gen_inner
      // Inner levels merge the two child nodes, left child first
      for (genvar k = 0; k < 2**lvl; k++) begin : gen_node
        assign sel_nodes[2**lvl-1+k] = sel_nodes[2**(lvl+1)-1+2*k]
                                     | sel_nodes[2**(lvl+1)-1+2*k+1];
        assign index_nodes[2**lvl-1+k] = sel_nodes[2**(lvl+1)-1+2*k]
                                       ? index_nodes[2**(lvl+1)-1+2*k]
                                       : index_nodes[2**(lvl+1)-1+2*k+1];
      end
    end
  end

  // The root carries the position of the first set bit
  assign cnt_o   = index_nodes[0];
  // No set bit anywhere below the root
  assign empty_o = ~sel_nodes[0];

endmodule : lzc

// File: logic/i2f_dispatch.sv
// Round-robin request dispatcher
`timescale 1ns/1ps

module i2f_dispatch (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                valid_i,
  input  logic [i2f_cfg_pkg::INT_W-1:0]       op_i,
  input  logic                                is_signed_i,
  input  logic [i2f_cfg_pkg::TAG_W-1:0]       tag_i,
  output logic [i2f_cfg_pkg::NUM_LANES-1:0]   lane_start_o,
  output logic [i2f_cfg_pkg::INT_W-1:0]       lane_op_o,
  output logic                                lane_signed_o,
  output logic [i2f_cfg_pkg::TAG_W-1:0]       lane_tag_o
);

  // Lane that receives the next request
  logic [i2f_cfg_pkg::LANE_IDX_W-1:0] rr_ptr_q;

  // One-hot start pattern for the current strobe
  logic [i2f_cfg_pkg::NUM_LANES-1:0] start_d;

  // Only the pointed lane starts, and only when a request is present
  always_comb begin
    for (int unsigned i = 0; i < i2f_cfg_pkg::NUM_LANES; i++) begin
      start_d[i] = valid_i && (rr_ptr_q == (i2f_cfg_pkg::LANE_IDX_W)'(i));
    end
  end

  // Control state, the start strobe lasts exactly one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q     <= '0;
      lane_start_o <= '0;
    end else begin
      lane_start_o <= start_d;
      if (valid_i) begin
        // Wrap explicitly so a lane count below 2^LANE_IDX_W also works
        if (rr_ptr_q == (i2f_cfg_pkg::LANE_IDX_W)'(i2f_cfg_pkg::NUM_LANES - 1)) begin
          rr_ptr_q <= '0;
        end else begin
          rr_ptr_q <= rr_ptr_q + 1'b1;
        end
      end
    end
  end

  // Shared request bus to all lanes
  // Only the started lane samples it, in the cycle the start bit is high
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      lane_op_o     <= op_i;
      lane_signed_o <= is_signed_i;
      lane_tag_o    <= tag_i;
    end
  end

endmodule : i2f_dispatch

// File: logic/i2f_lane.sv
// Integer to float conversion lane
`timescale 1ns/1ps

module i2f_lane (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            start_i,
  input  logic [i2f_cfg_pkg::INT_W-1:0]   op_i,
  input  logic                            is_signed_i,
  input  logic [i2f_cfg_pkg::TAG_W-1:0]   tag_i,
  output logic                            done_o,
  output i2f_fmt_pkg::f32_word_u          res_o,
  output logic                            inexact_o,
  output logic [i2f_cfg_pkg::TAG_W-1:0]   tag_o
);

  // Step counter, 0 is idle and 1 to LANE_LAT are the busy cycles
  logic [1:0] step_q;

  // Captured request
  logic [i2f_cfg_pkg::INT_W-1:0] op_q;
  logic                          is_signed_q;

  // Step 1 result, sign and magnitude
  logic                          neg_d;
  logic [i2f_cfg_pkg::INT_W-1:0] mag_d;
  logic                          sign_q;
  logic [i2f_cfg_pkg::INT_W-1:0] mag_q;

  // Step 2 result, normalized magnitude with its shift count
  logic [$clog2(i2f_cfg_pkg::INT_W)-1:0] lz_cnt;
  logic                                  lz_empty;
  logic [i2f_cfg_pkg::INT_W-1:0]         norm_q;
  logic [$clog2(i2f_cfg_pkg::INT_W)-1:0] cnt_q;
  logic                                  zero_q;

  // Step 3 rounding terms
  logic [i2f_fmt_pkg::MAN_W:0]   sig;
  logic                          guard;
  logic                          sticky;
  logic                          round_up;
  logic [i2f_fmt_pkg::MAN_W+1:0] rnd_sum;
  logic                          carry;
  i2f_fmt_pkg::f32_word_u        res_d;

  // Negative only for a signed operand with its top bit set
  // The most negative value negates to itself and still reads right as unsigned
  assign neg_d = is_signed_q & op_q[i2f_cfg_pkg::INT_W-1];
  assign mag_d = neg_d ? (~op_q + 1'b1) : op_q;

  lzc #(
    .WIDTH (i2f_cfg_pkg::INT_W),
    .MODE  (1'b1)
  ) lzc_i (
    .in_i    (mag_q),
    .cnt_o   (lz_cnt),
    .empty_o (lz_empty)
  );

  // After normalization the hidden one sits in the MSB
  assign sig    = norm_q[i2f_cfg_pkg::INT_W-1 -: i2f_fmt_pkg::MAN_W+1];
  // First dropped bit
  assign guard  = norm_q[i2f_cfg_pkg::INT_W-i2f_fmt_pkg::MAN_W-2];
  assign sticky = |norm_q[i2f_cfg_pkg::INT_W-i2f_fmt_pkg::MAN_W-3:0];

  // Ties go to the even significand
  assign round_up = guard & (sticky | sig[0]);
  assign rnd_sum  = {1'b0, sig} + (i2f_fmt_pkg::MAN_W+2)'(round_up);
  // Significand overflowed to 2.0, which needs one more exponent step
  assign carry    = rnd_sum[i2f_fmt_pkg::MAN_W+1];

  always_comb begin
    res_d.fields.sign = sign_q;
    // Value is 1.m times 2^(INT_W-1-count)
    res_d.fields.exp  = (i2f_fmt_pkg::EXP_W)'(i2f_fmt_pkg::EXP_BIAS + i2f_cfg_pkg::INT_W - 1)
                      - (i2f_fmt_pkg::EXP_W)'(cnt_q)
                      + (i2f_fmt_pkg::EXP_W)'(carry);
    res_d.fields.man  = carry ? rnd_sum[i2f_fmt_pkg::MAN_W:1]
                              : rnd_sum[i2f_fmt_pkg::MAN_W-1:0];
    // Zero has no leading one, so it is packed as +0
    if (zero_q) begin
      res_d.raw = '0;
    end
  end

  // Lane FSM, done is raised as the last step writes the result
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      step_q <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= (step_q == 2'(i2f_cfg_pkg::LANE_LAT));
      if (start_i) begin
        step_q <= 2'd1;
      end else if (step_q == 2'(i2f_cfg_pkg::LANE_LAT)) begin
        step_q <= '0;
      end else if (step_q != '0) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // Datapath, each stage register loads on its own step
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q        <= op_i;
      is_signed_q <= is_signed_i;
      tag_o       <= tag_i;
    end
    if (step_q == 2'd1) begin
      sign_q <= neg_d;
      mag_q  <= mag_d;
    end
    if (step_q == 2'd2) begin
      norm_q <= mag_q << lz_cnt;
      cnt_q  <= lz_cnt;
      zero_q <= lz_empty;
    end
    if (step_q == 2'd3) begin
      res_o     <= res_d;
      inexact_o <= guard | sticky;
    end
  end

endmodule : i2f_lane

// File: logic/i2f_collect.sv
// Lane result collector
`timescale 1ns/1ps

module i2f_collect (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  input  logic [i2f_cfg_pkg::NUM_LANES-1:0]                     lane_done_i,
  input  i2f_fmt_pkg::f32_word_u [i2f_cfg_pkg::NUM_LANES-1:0]   lane_res_i,
  input  logic [i2f_cfg_pkg::NUM_LANES-1:0]                     lane_inexact_i,
  input  logic [i2f_cfg_pkg::NUM_LANES-1:0][i2f_cfg_pkg::TAG_W-1:0] lane_tag_i,
  output logic                                                  valid_o,
  output logic [i2f_fmt_pkg::F32_W-1:0]                         res_o,
  output logic                                                  inexact_o,
  output logic [i2f_cfg_pkg::TAG_W-1:0]                         tag_o
);

  // Index of the lane that finishes this cycle
  logic [i2f_cfg_pkg::LANE_IDX_W-1:0] sel_idx;

  // Any lane finishing this cycle
  logic any_done;

  // Done bits are one-hot by construction, since starts come one per cycle
  // and every lane takes the same number of cycles
  always_comb begin
    sel_idx = '0;
    for (int unsigned i = 0; i < i2f_cfg_pkg::NUM_LANES; i++) begin
      if (lane_done_i[i]) begin
        sel_idx = (i2f_cfg_pkg::LANE_IDX_W)'(i);
      end
    end
  end

  assign any_done = |lane_done_i;

  // Output strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= any_done;
    end
  end

  // Output payload, held between strobes
  always_ff @(posedge clk_i) begin
    if (any_done) begin
      res_o     <= lane_res_i[sel_idx].raw;
      inexact_o <= lane_inexact_i[sel_idx];
      tag_o     <= lane_tag_i[sel_idx];
    end
  end

endmodule : i2f_collect

// File: logic/i2f_top.sv
// Integer to float converter top level
`timescale 1ns/1ps

module i2f_top (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            valid_i,
  input  logic [i2f_cfg_pkg::INT_W-1:0]   op_i,
  input  logic                            is_signed_i,
  input  logic [i2f_cfg_pkg::TAG_W-1:0]   tag_i,
  output logic                            valid_o,
  output logic [i2f_fmt_pkg::F32_W-1:0]   res_o,
  output logic                            inexact_o,
  output logic [i2f_cfg_pkg::TAG_W-1:0]   tag_o
);

  // Shared request bus from the dispatcher
  logic [i2f_cfg_pkg::NUM_LANES-1:0] lane_start;
  logic [i2f_cfg_pkg::INT_W-1:0]     lane_op;
  logic                              lane_signed;
  logic [i2f_cfg_pkg::TAG_W-1:0]     lane_tag;

  // Per-lane results toward the collector
  logic [i2f_cfg_pkg::NUM_LANES-1:0]                         lane_done;
  i2f_fmt_pkg::f32_word_u [i2f_cfg_pkg::NUM_LANES-1:0]       lane_res;
  logic [i2f_cfg_pkg::NUM_LANES-1:0]                         lane_inexact;
  logic [i2f_cfg_pkg::NUM_LANES-1:0][i2f_cfg_pkg::TAG_W-1:0] lane_tag_out;

  i2f_dispatch i2f_dispatch_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (valid_i),
    .op_i          (op_i),
    .is_signed_i   (is_signed_i),
    .tag_i         (tag_i),
    .lane_start_o  (lane_start),
    .lane_op_o     (lane_op),
    .lane_signed_o (lane_signed),
    .lane_tag_o    (lane_tag)
  );

  // All lanes see the same request bus, only the started one samples it
  for (genvar g = 0; g < i2f_cfg_pkg::NUM_LANES; g++) begin : gen_lane
    i2f_lane i2f_lane_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .start_i     (lane_start[g]),
      .op_i        (lane_op),
      .is_signed_i (lane_signed),
      .tag_i       (lane_tag),
      .done_o      (lane_done[g]),
      .res_o       (lane_res[g]),
      .inexact_o   (lane_inexact[g]),
      .tag_o       (lane_tag_out[g])
    );
  end

  i2f_collect i2f_collect_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .lane_done_i    (lane_done),
    .lane_res_i     (lane_res),
    .lane_inexact_i (lane_inexact),
    .lane_tag_i     (lane_tag_out),
    .valid_o        (valid_o),
    .res_o          (res_o),
    .inexact_o      (inexact_o),
    .tag_o          (tag_o)
  );

endmodule : i2f_top

// File: tests/i2f_asserts.sv
// Lane timing assertions
`timescale 1ns/1ps

module i2f_asserts (
  input logic clk_i,
  input logic arst_n_i,
  input logic start_i,
  input logic done_i
);

  // Failures seen by this instance, summed by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // A captured start gives done on the fourth sampling edge
  // That is three busy cycles, then the strobe
  done_after_start: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    start_i |=> (!done_i) [*i2f_cfg_pkg::LANE_LAT] ##1 done_i
  ) else begin
    $error("Lane done did not follow its start by exactly %0d cycles",
           i2f_cfg_pkg::LANE_LAT);
    fail_cnt++;
  end

  // The lane is busy for LANE_LAT cycles after a start and must see no new one
  no_start_when_busy: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    start_i |=> (!start_i) [*i2f_cfg_pkg::LANE_LAT]
  ) else begin
    $error("Lane received a start while still busy");
    fail_cnt++;
  end

  // Done is a single-cycle strobe
  done_single_cycle: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    done_i |=> !done_i
  ) else begin
    $error("Lane done stayed high for two cycles in a row");
    fail_cnt++;
  end

endmodule : i2f_asserts

bind i2f_lane i2f_asserts i2f_asserts_i (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .start_i  (start_i),
  .done_i   (done_o)
);

// File: tests/i2f_tb.sv
// Integer to float converter testbench
`timescale 1ns/1ps

module i2f_tb;

  localparam int unsigned NUM_VEC    = 38;
  localparam int unsigned CLK_PERIOD = 10;
  // Cycles from the edge that samples a request to the edge that raises valid_o
  localparam int unsigned LATENCY    = 5;
  localparam int unsigned DRAIN_MAX  = 200;
  localparam int unsigned BURST_LEN  = 20;

  logic                          clk;
  logic                          arst_n;
  logic                          valid_in;
  logic [i2f_cfg_pkg::INT_W-1:0] op_in;
  logic                          signed_in;
  logic [i2f_cfg_pkg::TAG_W-1:0] tag_in;
  logic                          valid_out;
  logic [i2f_fmt_pkg::F32_W-1:0] res_out;
  logic                          inexact_out;
  logic [i2f_cfg_pkg::TAG_W-1:0] tag_out;

  // Four words per vector: signed flag, operand, result word, inexact flag
  logic [31:0] vec_mem [0:4*NUM_VEC-1];

  // Expectations in request order, with the time of the edge that samples each request
  logic [31:0]                   exp_res_q[$];
  logic                          exp_inexact_q[$];
  logic [i2f_cfg_pkg::TAG_W-1:0] exp_tag_q[$];
  time                           exp_time_q[$];

  logic [i2f_cfg_pkg::TAG_W-1:0] next_tag;
  int unsigned err_cnt    = 0;
  int unsigned check_cnt  = 0;
  int unsigned err_base   = 0;
  int unsigned check_base = 0;
  int unsigned test_cnt   = 0;
  int unsigned lane_hits [i2f_cfg_pkg::NUM_LANES];

  i2f_top i2f_top_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .valid_i     (valid_in),
    .op_i        (op_in),
    .is_signed_i (signed_in),
    .tag_i       (tag_in),
    .valid_o     (valid_out),
    .res_o       (res_out),
    .inexact_o   (inexact_out),
    .tag_o       (tag_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $finish;
  endtask

  // Drives one vector for one cycle and queues what should come back
  task automatic send_request(input int unsigned idx);
    @(posedge clk);
    valid_in  <= 1'b1;
    op_in     <= vec_mem[4*idx+1];
    signed_in <= vec_mem[4*idx][0];
    tag_in    <= next_tag;
    exp_res_q.push_back(vec_mem[4*idx+2]);
    exp_inexact_q.push_back(vec_mem[4*idx+3][0]);
    exp_tag_q.push_back(next_tag);
    // The DUT samples the strobe one edge later
    exp_time_q.push_back($time + CLK_PERIOD);
    next_tag = next_tag + 1'b1;
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      valid_in <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (exp_res_q.size() != 0 && waited < DRAIN_MAX) begin
      @(posedge clk);
      waited++;
    end
    if (exp_res_q.size() != 0) begin
      abort_run($sformatf("Timed out with %0d results still missing", exp_res_q.size()));
    end
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    $display("Test %0d (%s) finished: %0d checks, %0d errors", test_cnt, name,
             check_cnt - check_base, err_cnt - err_base);
    check_base = check_cnt;
    err_base   = err_cnt;
  endtask

  // Failure counts of the bound lane assertions
  function automatic int unsigned assert_failures();
    return i2f_top_i.gen_lane[0].i2f_lane_i.i2f_asserts_i.fail_cnt
         + i2f_top_i.gen_lane[1].i2f_lane_i.i2f_asserts_i.fail_cnt
         + i2f_top_i.gen_lane[2].i2f_lane_i.i2f_asserts_i.fail_cnt
         + i2f_top_i.gen_lane[3].i2f_lane_i.i2f_asserts_i.fail_cnt;
  endfunction

  // Output monitor, sampled at the falling edge where every output is settled
  always @(negedge clk) begin : monitor
    logic [31:0]                   exp_res;
    logic                          exp_inexact;
    logic [i2f_cfg_pkg::TAG_W-1:0] exp_tag;
    time                           req_time;
    if (arst_n) begin
      for (int unsigned i = 0; i < i2f_cfg_pkg::NUM_LANES; i++) begin
        if (i2f_top_i.lane_done[i]) begin
          lane_hits[i]++;
        end
      end
      if (valid_out && exp_res_q.size() == 0) begin
        err_cnt++;
        $display("Output strobe at time %0t with no request outstanding", $time);
      end else if (valid_out) begin
        exp_res     = exp_res_q.pop_front();
        exp_inexact = exp_inexact_q.pop_front();
        exp_tag     = exp_tag_q.pop_front();
        req_time    = exp_time_q.pop_front();
        compare_value("result", res_out, exp_res);
        compare_value("inexact", 32'(inexact_out), 32'(exp_inexact));
        compare_value("tag", 32'(tag_out), 32'(exp_tag));
        // valid_o rose half a period before this falling edge
        compare_value("latency", 32'(($time - CLK_PERIOD / 2 - req_time) / CLK_PERIOD),
                      LATENCY);
      end
    end
  end

  initial begin : stimulus
    int unsigned gap;
    int unsigned total_err;
    void'($urandom(32'h5630));
    arst_n    = 1'b0;
    valid_in  = 1'b0;
    op_in     = '0;
    signed_in = 1'b0;
    tag_in    = '0;
    next_tag  = '0;
    $readmemh("tests/i2f_vectors.txt", vec_mem);
    for (int unsigned i = 0; i < 4 * NUM_VEC; i++) begin
      if ($isunknown(vec_mem[i])) begin
        abort_run("Vector file tests/i2f_vectors.txt is missing or incomplete");
      end
    end
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    // No strobe may appear before the first request
    repeat (8) begin
      @(negedge clk);
      compare_value("idle valid_o", 32'(valid_out), 32'd0);
    end
    report_test("reset idle");

    // One request in flight at a time
    for (int unsigned i = 0; i < NUM_VEC; i++) begin
      send_request(i);
      idle_cycles(1);
      wait_drain();
    end
    report_test("single vectors");

    // A strobe every cycle walks the round-robin pointer through every lane
    for (int unsigned i = 0; i < i2f_cfg_pkg::NUM_LANES; i++) begin
      lane_hits[i] = 0;
    end
    for (int unsigned i = 0; i < BURST_LEN; i++) begin
      send_request((i * 7 + 3) % NUM_VEC);
    end
    idle_cycles(1);
    wait_drain();
    for (int unsigned i = 0; i < i2f_cfg_pkg::NUM_LANES; i++) begin
      compare_value($sformatf("lane %0d results", i), lane_hits[i],
                    BURST_LEN / i2f_cfg_pkg::NUM_LANES);
    end
    report_test("back-to-back burst");

    // Random idle gaps of zero to three cycles between requests
    for (int unsigned i = 0; i < NUM_VEC; i++) begin
      send_request(i);
      gap = $urandom % 4;
      if (gap != 0) begin
        idle_cycles(gap);
      end
    end
    idle_cycles(1);
    wait_drain();
    report_test("random gaps");

    total_err = err_cnt + assert_failures();
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, check_cnt, err_cnt, assert_failures());
    if (total_err == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : i2f_tb

// File: tests/i2f_vectors.txt
// Columns: signed flag, operand, expected result word, expected inexact flag
// All fields in hex, one request per line
// Exact small integers and powers of two
0 00000001 3f800000 0
1 00000001 3f800000 0
0 00000002 40000000 0
0 00000003 40400000 0
1 fffffffd c0400000 0
0 0000000a 41200000 0
0 00000064 42c80000 0
1 ffffff9c c2c80000 0
0 00000400 44800000 0
0 40000000 4e800000 0
0 80000000 4f000000 0
0 00ffffff 4b7fffff 0
0 01000000 4b800000 0
1 ff000000 cb800000 0
0 7fffff80 4effffff 0
0 01000002 4b800001 0
// Edge operands
0 00000000 00000000 0
1 80000000 cf000000 0
0 ffffffff 4f800000 1
1 ffffffff bf800000 0
1 7fffffff 4f000000 1
1 80000001 cf000000 1
// Near and exact halfway points, ties go to even
0 01000001 4b800000 1
0 01000003 4b800002 1
0 02000001 4c000000 1
0 02000002 4c000000 1
0 02000003 4c000001 1
0 02000006 4c000002 1
0 04000003 4c800000 1
0 04000004 4c800000 1
0 04000005 4c800001 1
0 0400000c 4c800002 1
0 80000080 4f000000 1
0 80000081 4f000001 1
0 ffffff7f 4f7fffff 1
0 ffffff80 4f800000 1
1 fdfffffa cc000002 1
0 12345678 4d91a2b4 1

// File: sim.f
logic/i2f_cfg_pkg.sv
logic/i2f_fmt_pkg.sv
logic/lzc.sv
logic/i2f_dispatch.sv
logic/i2f_lane.sv
logic/i2f_collect.sv
logic/i2f_top.sv
tests/i2f_asserts.sv
tests/i2f_tb.sv
